// File: common/cdc_fifo_pkg.sv
// ------------------------------------------------
// Dual-clock FIFO shared sizes and types
// Used by the push side, the pop side and the RAM
// ------------------------------------------------

package cdc_fifo_pkg;

  // ------------------------------------------------
  // Storage geometry
  // ------------------------------------------------
  // Number of FIFO entries
  localparam int depth = 8;
  // Width of one stored word
  localparam int data_width = 16;
  // RAM address width for depth entries
  localparam int addr_width = 3;
  // One extra bit so a full FIFO and an empty FIFO differ
  localparam int count_width = 4;

  // ------------------------------------------------
  // Clock crossing
  // ------------------------------------------------
  // Destination flops per Gray count crossing
  localparam int sync_stages = 2;

  // Pop staging register state
  typedef enum logic [1:0] {
    STAGE_EMPTY,    // Nothing held and no read in flight
    STAGE_READING,  // RAM read issued, data due next cycle
    STAGE_FULL      // Word held and offered on pop_valid
  } pop_stage_e;

endpackage

// File: rtl/gray_count_sync.sv
// ------------------------------------------------
// Gray count synchronizer
// Carries a binary count and a status flag into another clock domain
// ------------------------------------------------
`timescale 1ns/1ps

module gray_count_sync
  import cdc_fifo_pkg::*;
(
  input  logic                   src_clk,
  input  logic                   dst_clk,
  input  logic                   rst_n,
  input  logic [count_width-1:0] src_count,
  input  logic                   src_flag,
  output logic [count_width-1:0] dst_count,
  output logic                   dst_flag
);

  // Gray word launched from a source-domain flop
  logic [count_width-1:0] src_gray;
  // Synchronizer chains, index 0 samples the source
  logic [count_width-1:0] sync_gray [sync_stages];
  logic                   sync_flag [sync_stages];

  // Gray back to binary, MSB passes straight through
  function automatic logic [count_width-1:0] gray_to_bin(
    input logic [count_width-1:0] gray
  );
    logic [count_width-1:0] bin;
    bin[count_width-1] = gray[count_width-1];
    for (int i = count_width - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  // ------------------------------------------------
  // Source domain
  // ------------------------------------------------
  // Only one bit flips per count step, so the crossing is safe
  always_ff @(posedge src_clk) begin
    if (!rst_n) begin
      src_gray <= '0;
    end else begin
      src_gray <= src_count ^ (src_count >> 1);
    end
  end

  // ------------------------------------------------
  // Destination domain
  // ------------------------------------------------
  // Flag resets high so the far side looks busy until proven otherwise
  always_ff @(posedge dst_clk) begin
    if (!rst_n) begin
      for (int i = 0; i < sync_stages; i++) begin
        sync_gray[i] <= '0;
        sync_flag[i] <= 1'b1;
      end
    end else begin
      sync_gray[0] <= src_gray;
      sync_flag[0] <= src_flag;
      for (int i = 1; i < sync_stages; i++) begin
        sync_gray[i] <= sync_gray[i-1];
        sync_flag[i] <= sync_flag[i-1];
      end
    end
  end

  assign dst_count = gray_to_bin(sync_gray[sync_stages-1]);
  assign dst_flag  = sync_flag[sync_stages-1];

endmodule

// File: rtl/dual_clock_ram.sv
// ------------------------------------------------
// 1R1W storage array with one write clock and one read clock
// ------------------------------------------------
`timescale 1ns/1ps

module dual_clock_ram
  import cdc_fifo_pkg::*;
(
  input  logic                  wr_clk,
  input  logic                  rd_clk,
  input  logic                  rst_n,
  input  logic                  wr_valid,
  input  logic [addr_width-1:0] wr_addr,
  input  logic [data_width-1:0] wr_data,
  input  logic                  rd_addr_valid,
  input  logic [addr_width-1:0] rd_addr,
  output logic                  rd_data_valid,
  output logic [data_width-1:0] rd_data
);

  logic [data_width-1:0] mem [depth];

  // Write port
  always_ff @(posedge wr_clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read data, one cycle after the address
  always_ff @(posedge rd_clk) begin
    if (rd_addr_valid) begin
      rd_data <= mem[rd_addr];
    end
  end

  // Read valid marks the cycle the data is usable
  always_ff @(posedge rd_clk) begin
    if (!rst_n) begin
      rd_data_valid <= 1'b0;
    end else begin
      rd_data_valid <= rd_addr_valid;
    end
  end

endmodule

// File: cdc_fifo/cdc_fifo_ctrl_push.sv
// ------------------------------------------------
// Push side of the dual-clock FIFO controller
// Write pointer, full status, item count and push reset flag
// ------------------------------------------------
`timescale 1ns/1ps

module cdc_fifo_ctrl_push
  import cdc_fifo_pkg::*;
(
  input  logic                   push_clk,
  input  logic                   pop_clk,
  input  logic                   rst_n,
  // Push port
  input  logic                   push_valid,
  input  logic [data_width-1:0]  push_data,
  output logic                   push_ready,
  // Status
  output logic                   push_full,
  output logic [count_width-1:0] push_items,
  // Link to the pop side
  input  logic [count_width-1:0] pop_count,
  input  logic                   pop_reset_active,
  output logic [count_width-1:0] push_count,
  output logic                   push_reset_active,
  // RAM write port
  output logic                   ram_wr_valid,
  output logic [addr_width-1:0]  ram_wr_addr,
  output logic [data_width-1:0]  ram_wr_data
);

  logic [count_width-1:0] wr_count;
  logic [count_width-1:0] wr_count_next;
  logic [count_width-1:0] pop_count_sync;
  logic                   pop_reset_sync;
  logic                   push_fire;

  // ------------------------------------------------
  // Pop count and pop reset flag into push_clk
  // ------------------------------------------------
  gray_count_sync u_pop2push_sync (
    .src_clk  (pop_clk),
    .dst_clk  (push_clk),
    .rst_n    (rst_n),
    .src_count(pop_count),
    .src_flag (pop_reset_active),
    .dst_count(pop_count_sync),
    .dst_flag (pop_reset_sync)
  );

  // Push reset flag leaves from a flop
  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      push_reset_active <= 1'b1;
    end else begin
      push_reset_active <= 1'b0;
    end
  end

  // ------------------------------------------------
  // Occupancy and handshake
  // ------------------------------------------------
  // Lagging pop count makes this an overestimate, never an underestimate
  assign push_items = wr_count - pop_count_sync;
  assign push_full  = (push_items == count_width'(depth));

  // No push while either side is still coming out of reset
  assign push_ready = !push_full && !push_reset_active && !pop_reset_sync;
  assign push_fire  = push_valid && push_ready;

  assign wr_count_next = wr_count + count_width'(push_fire);

  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      wr_count <= '0;
    end else begin
      wr_count <= wr_count_next;
    end
  end

  // Next count feeds the Gray register, so it moves on the push edge
  assign push_count = wr_count_next;

  // ------------------------------------------------
  // RAM write
  // ------------------------------------------------
  // Written on the same edge that accepts the push
  assign ram_wr_valid = push_fire;
  assign ram_wr_addr  = wr_count[addr_width-1:0];
  assign ram_wr_data  = push_data;

endmodule

// File: cdc_fifo/cdc_fifo_pop_ctrl.sv
// ------------------------------------------------
// Pop-domain core of the dual-clock FIFO
// Read pointer, RAM read issue, staging register and empty status
// ------------------------------------------------
`timescale 1ns/1ps

module cdc_fifo_pop_ctrl
  import cdc_fifo_pkg::*;
(
  input  logic                   pop_clk,
  input  logic                   rst_n,
  // Pop port
  input  logic                   pop_ready,
  output logic                   pop_valid,
  output logic [data_width-1:0]  pop_data,
  // Status
  output logic                   pop_empty,
  output logic [count_width-1:0] pop_items,
  // Synchronized push side state
  input  logic [count_width-1:0] push_count,
  input  logic                   push_reset_active,
  // Count sent back to the push side
  output logic [count_width-1:0] pop_count,
  // RAM read port
  output logic                   ram_rd_addr_valid,
  output logic [addr_width-1:0]  ram_rd_addr,
  input  logic                   ram_rd_data_valid,
  input  logic [data_width-1:0]  ram_rd_data
);

  pop_stage_e             stage;
  pop_stage_e             stage_next;
  // Reads issued to the RAM
  logic [count_width-1:0] rd_count;
  // Words handed out on the pop port
  logic [count_width-1:0] popped_count;
  logic                   pop_fire;
  logic                   can_read;
  logic                   rd_issue;

  // ------------------------------------------------
  // Read issue and staging FSM
  // ------------------------------------------------
  assign pop_valid = (stage == STAGE_FULL);
  assign pop_fire  = pop_valid && pop_ready;

  // Words in the RAM that have not been read yet
  assign can_read = (push_count != rd_count) && !push_reset_active;

  always_comb begin
    stage_next = stage;
    rd_issue   = 1'b0;
    case (stage)
      STAGE_EMPTY: begin
        if (can_read) begin
          rd_issue   = 1'b1;
          stage_next = STAGE_READING;
        end
      end
      STAGE_READING: begin
        // Data always returns one cycle after the read
        if (ram_rd_data_valid) begin
          stage_next = STAGE_FULL;
        end
      end
      STAGE_FULL: begin
        // Refill in the same cycle the held word leaves
        if (pop_fire) begin
          if (can_read) begin
            rd_issue   = 1'b1;
            stage_next = STAGE_READING;
          end else begin
            stage_next = STAGE_EMPTY;
          end
        end
      end
      default: begin
        stage_next = STAGE_EMPTY;
      end
    endcase
  end

  always_ff @(posedge pop_clk) begin
    if (!rst_n) begin
      stage        <= STAGE_EMPTY;
      rd_count     <= '0;
      popped_count <= '0;
    end else begin
      stage        <= stage_next;
      rd_count     <= rd_count + count_width'(rd_issue);
      popped_count <= popped_count + count_width'(pop_fire);
    end
  end

  // Staging register, held while pop_ready is low
  always_ff @(posedge pop_clk) begin
    if (stage == STAGE_READING && ram_rd_data_valid) begin
      pop_data <= ram_rd_data;
    end
  end

  assign ram_rd_addr_valid = rd_issue;
  assign ram_rd_addr       = rd_count[addr_width-1:0];

  // ------------------------------------------------
  // Status and return count
  // ------------------------------------------------
  // Staged word still counts until it is popped
  assign pop_items = push_count - popped_count;
  assign pop_empty = (pop_items == '0);

  // Slot is released to the push side on the pop edge
  assign pop_count = popped_count + count_width'(pop_fire);

endmodule

// File: cdc_fifo/cdc_fifo_ctrl_pop.sv
// ------------------------------------------------
// Pop side of the dual-clock FIFO controller
// Push count crossing, pop reset flag and the pop core
// ------------------------------------------------
`timescale 1ns/1ps

module cdc_fifo_ctrl_pop
  import cdc_fifo_pkg::*;
(
  input  logic                   push_clk,
  input  logic                   pop_clk,
  input  logic                   rst_n,
  // Link to the push side
  input  logic [count_width-1:0] push_count,
  input  logic                   push_reset_active,
  output logic [count_width-1:0] pop_count,
  output logic                   pop_reset_active,
  // Pop port
  input  logic                   pop_ready,
  output logic                   pop_valid,
  output logic [data_width-1:0]  pop_data,
  // Status
  output logic                   pop_empty,
  output logic [count_width-1:0] pop_items,
  // RAM read port
  output logic                   ram_rd_addr_valid,
  output logic [addr_width-1:0]  ram_rd_addr,
  input  logic                   ram_rd_data_valid,
  input  logic [data_width-1:0]  ram_rd_data
);

  logic [count_width-1:0] push_count_sync;
  logic                   push_reset_sync;

  // Push count and push reset flag into pop_clk
  gray_count_sync u_push2pop_sync (
    .src_clk  (push_clk),
    .dst_clk  (pop_clk),
    .rst_n    (rst_n),
    .src_count(push_count),
    .src_flag (push_reset_active),
    .dst_count(push_count_sync),
    .dst_flag (push_reset_sync)
  );

  // Flag leaves from a flop before the crossing
  always_ff @(posedge pop_clk) begin
    if (!rst_n) begin
      pop_reset_active <= 1'b1;
    end else begin
      pop_reset_active <= 1'b0;
    end
  end

  cdc_fifo_pop_ctrl u_pop_ctrl (
    .pop_clk          (pop_clk),
    .rst_n            (rst_n),
    .pop_ready        (pop_ready),
    .pop_valid        (pop_valid),
    .pop_data         (pop_data),
    .pop_empty        (pop_empty),
    .pop_items        (pop_items),
    .push_count       (push_count_sync),
    .push_reset_active(push_reset_sync),
    .pop_count        (pop_count),
    .ram_rd_addr_valid(ram_rd_addr_valid),
    .ram_rd_addr      (ram_rd_addr),
    .ram_rd_data_valid(ram_rd_data_valid),
    .ram_rd_data      (ram_rd_data)
  );

endmodule

// File: cdc_fifo/cdc_fifo.sv
// ------------------------------------------------
// Dual-clock FIFO top with push side, pop side and 1R1W RAM
// ------------------------------------------------
`timescale 1ns/1ps

module cdc_fifo
  import cdc_fifo_pkg::*;
(
  input  logic                   push_clk,
  input  logic                   pop_clk,
  input  logic                   rst_n,
  // Push domain
  input  logic                   push_valid,
  input  logic [data_width-1:0]  push_data,
  output logic                   push_ready,
  output logic                   push_full,
  output logic [count_width-1:0] push_items,
  // Pop domain
  input  logic                   pop_ready,
  output logic                   pop_valid,
  output logic [data_width-1:0]  pop_data,
  output logic                   pop_empty,
  output logic [count_width-1:0] pop_items
);

  // Counts and reset flags between the two sides
  logic [count_width-1:0] push_count;
  logic                   push_reset_active;
  logic [count_width-1:0] pop_count;
  logic                   pop_reset_active;

  // RAM ports
  logic                   ram_wr_valid;
  logic [addr_width-1:0]  ram_wr_addr;
  logic [data_width-1:0]  ram_wr_data;
  logic                   ram_rd_addr_valid;
  logic [addr_width-1:0]  ram_rd_addr;
  logic                   ram_rd_data_valid;
  logic [data_width-1:0]  ram_rd_data;

  cdc_fifo_ctrl_push u_ctrl_push (
    .push_clk         (push_clk),
    .pop_clk          (pop_clk),
    .rst_n            (rst_n),
    .push_valid       (push_valid),
    .push_data        (push_data),
    .push_ready       (push_ready),
    .push_full        (push_full),
    .push_items       (push_items),
    .pop_count        (pop_count),
    .pop_reset_active (pop_reset_active),
    .push_count       (push_count),
    .push_reset_active(push_reset_active),
    .ram_wr_valid     (ram_wr_valid),
    .ram_wr_addr      (ram_wr_addr),
    .ram_wr_data      (ram_wr_data)
  );

  cdc_fifo_ctrl_pop u_ctrl_pop (
    .push_clk         (push_clk),
    .pop_clk          (pop_clk),
    .rst_n            (rst_n),
    .push_count       (push_count),
    .push_reset_active(push_reset_active),
    .pop_count        (pop_count),
    .pop_reset_active (pop_reset_active),
    .pop_ready        (pop_ready),
    .pop_valid        (pop_valid),
    .pop_data         (pop_data),
    .pop_empty        (pop_empty),
    .pop_items        (pop_items),
    .ram_rd_addr_valid(ram_rd_addr_valid),
    .ram_rd_addr      (ram_rd_addr),
    .ram_rd_data_valid(ram_rd_data_valid),
    .ram_rd_data      (ram_rd_data)
  );

  // Write side on push_clk, read side on pop_clk
  dual_clock_ram u_ram (
    .wr_clk       (push_clk),
    .rd_clk       (pop_clk),
    .rst_n        (rst_n),
    .wr_valid     (ram_wr_valid),
    .wr_addr      (ram_wr_addr),
    .wr_data      (ram_wr_data),
    .rd_addr_valid(ram_rd_addr_valid),
    .rd_addr      (ram_rd_addr),
    .rd_data_valid(ram_rd_data_valid),
    .rd_data      (ram_rd_data)
  );

endmodule

// File: dv/cdc_fifo_tb.sv
// ------------------------------------------------
// Dual-clock FIFO testbench
// Random push and pop traffic, reference record, assertions and watchdog
// ------------------------------------------------
`timescale 1ns/1ps

module cdc_fifo_tb
  import cdc_fifo_pkg::*;
();

  // ------------------------------------------------
  // Test constants
  // ------------------------------------------------
  localparam int  idx_width      = 8;
  localparam int  num_words      = 1 << idx_width;
  localparam int  gate_len       = 1024;
  localparam real push_period_ns = 4.0;
  // Pop edges land on odd tenths of a ns and never meet push edges
  localparam real pop_period_ns  = 6.8;
  localparam real pop_offset_ns  = 0.5;
  localparam int  margin         = 10;
  localparam real watchdog_ns    = num_words * pop_period_ns * margin + 100.0;

  // Pop side traffic modes
  localparam int mode_random = 0;
  localparam int mode_stall  = 1;
  localparam int mode_drain  = 2;

  logic                   push_clk;
  logic                   pop_clk;
  logic                   rst_n      = 1'b0;
  logic                   push_valid = 1'b0;
  logic [data_width-1:0]  push_data  = '0;
  logic                   push_ready;
  logic                   push_full;
  logic [count_width-1:0] push_items;
  logic                   pop_ready  = 1'b0;
  logic                   pop_valid;
  logic [data_width-1:0]  pop_data;
  logic                   pop_empty;
  logic [count_width-1:0] pop_items;

  integer seed = 44105;
  // Stimulus tables filled once from the seed
  logic [data_width-1:0]  stim_words [num_words];
  logic                   push_gate [gate_len];
  logic                   pop_gate [gate_len];
  logic [9:0]             push_cyc    = '0;
  logic [9:0]             pop_cyc     = '0;
  logic                   push_enable = 1'b0;
  logic                   push_burst  = 1'b0;
  int                     pop_mode    = mode_stall;

  // Reference record of accepted pushes indexed by the push and pop totals
  logic [data_width-1:0]  pushed_words [num_words];
  int                     push_total = 0;
  int                     pop_total  = 0;
  logic                   push_taken = 1'b0;
  logic [data_width-1:0]  exp_head;
  // Pop data seen on the previous pop edge
  logic [data_width-1:0]  pop_data_q;
  // Reset seen on the previous edge of each domain
  logic                   push_rst_q = 1'b0;
  logic                   pop_rst_q  = 1'b0;

  cdc_fifo dut0 (
    .push_clk  (push_clk),
    .pop_clk   (pop_clk),
    .rst_n     (rst_n),
    .push_valid(push_valid),
    .push_data (push_data),
    .push_ready(push_ready),
    .push_full (push_full),
    .push_items(push_items),
    .pop_ready (pop_ready),
    .pop_valid (pop_valid),
    .pop_data  (pop_data),
    .pop_empty (pop_empty),
    .pop_items (pop_items)
  );

  // ------------------------------------------------
  // Failure reporting
  // ------------------------------------------------
  task automatic stop_on_failure();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string test, input int expected, input int actual);
    $display("[ERROR] %s: expected %0d, actual %0d", test, expected, actual);
    stop_on_failure();
  endtask

  // Clocks
  initial begin : gen_push_clk
    push_clk = 1'b0;
    forever #(push_period_ns / 2.0) push_clk = ~push_clk;
  end

  initial begin : gen_pop_clk
    pop_clk = 1'b0;
    #(pop_offset_ns);
    forever #(pop_period_ns / 2.0) pop_clk = ~pop_clk;
  end

  // ------------------------------------------------
  // Drivers on the falling edge of their own clock
  // ------------------------------------------------
  always @(negedge push_clk) begin
    if (push_valid && !push_taken) begin
      // Offered word waits for push_ready
      push_valid = 1'b1;
    end else if (push_enable && push_total < num_words) begin
      push_valid = push_burst || push_gate[push_cyc];
      push_data  = stim_words[push_total[idx_width-1:0]];
    end else begin
      push_valid = 1'b0;
    end
    push_cyc = push_cyc + 10'd1;
  end

  always @(negedge pop_clk) begin
    case (pop_mode)
      mode_stall: pop_ready = 1'b0;
      mode_drain: pop_ready = 1'b1;
      default:    pop_ready = pop_gate[pop_cyc];
    endcase
    pop_cyc = pop_cyc + 10'd1;
  end

  // ------------------------------------------------
  // Monitors
  // ------------------------------------------------
  always @(posedge push_clk) begin
    push_rst_q <= !rst_n;
    push_taken <= push_valid && push_ready;
    if (rst_n && push_valid && push_ready) begin
      pushed_words[push_total[idx_width-1:0]] <= push_data;
      push_total <= push_total + 1;
    end
  end

  always @(posedge pop_clk) begin
    pop_rst_q  <= !rst_n;
    pop_data_q <= pop_data;
    if (rst_n && pop_valid && pop_ready) begin
      pop_total <= pop_total + 1;
    end
  end

  // Oldest word not yet popped
  assign exp_head = pushed_words[pop_total[idx_width-1:0]];

  // ------------------------------------------------
  // Assertions
  // ------------------------------------------------
  // Reset state during reset and on the first edge after it
  assert property (@(posedge push_clk) push_rst_q |-> (!push_ready && push_items == '0))
    else report_mismatch("reset_push", 0,
                         int'($sampled(push_ready)) + int'($sampled(push_items)));
  assert property (@(posedge pop_clk)
    pop_rst_q |-> (!pop_valid && pop_empty && pop_items == '0))
    else report_mismatch("reset_pop", 0,
                         int'($sampled(pop_valid)) + int'(!$sampled(pop_empty)) +
                         int'($sampled(pop_items)));

  // Order and integrity
  assert property (@(posedge pop_clk) disable iff (!rst_n)
    (pop_valid && pop_ready) |-> (pop_data == exp_head))
    else report_mismatch("pop_order", int'($sampled(exp_head)), int'($sampled(pop_data)));
  assert property (@(posedge pop_clk) disable iff (!rst_n)
    (pop_valid && pop_ready) |-> (pop_total < push_total))
    else report_mismatch("pop_underflow", $sampled(push_total), $sampled(pop_total) + 1);

  // Full back-pressure
  assert property (@(posedge push_clk) disable iff (!rst_n)
    (push_total - pop_total) <= depth)
    else report_mismatch("stall_limit", depth, $sampled(push_total) - $sampled(pop_total));
  assert property (@(posedge push_clk) disable iff (!rst_n)
    push_full == (int'(push_items) == depth))
    else report_mismatch("full_flag", int'($sampled(push_items)) == depth,
                         int'($sampled(push_full)));
  assert property (@(posedge push_clk) disable iff (!rst_n) push_full |-> !push_ready)
    else report_mismatch("full_ready", 0, int'($sampled(push_ready)));

  // Pop stability under back-pressure
  assert property (@(posedge pop_clk) disable iff (!rst_n)
    ($past(pop_valid) && !$past(pop_ready)) |-> (pop_valid && pop_data == pop_data_q))
    else report_mismatch("pop_hold", int'($sampled(pop_data_q)), int'($sampled(pop_data)));

  // Empty status and conservative counts
  assert property (@(posedge pop_clk) disable iff (!rst_n) pop_empty |-> !pop_valid)
    else report_mismatch("empty_valid", 0, int'($sampled(pop_valid)));
  assert property (@(posedge pop_clk) disable iff (!rst_n)
    int'(pop_items) <= (push_total - pop_total))
    else report_mismatch("pop_items", $sampled(push_total) - $sampled(pop_total),
                         int'($sampled(pop_items)));
  assert property (@(posedge push_clk) disable iff (!rst_n)
    int'(push_items) >= (push_total - pop_total))
    else report_mismatch("push_items", $sampled(push_total) - $sampled(pop_total),
                         int'($sampled(push_items)));

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------
  initial begin : main_flow
    logic [31:0] r;
    for (int i = 0; i < num_words; i++) begin
      r = $random(seed);
      stim_words[i] = r[data_width-1:0];
    end
    for (int i = 0; i < gate_len; i++) begin
      push_gate[i] = ($random(seed) & 1) != 0;
      pop_gate[i]  = ($random(seed) & 3) != 0;
    end

    repeat (5) @(posedge pop_clk);
    @(negedge pop_clk);
    rst_n = 1'b1;

    // Fill with pop stalled until full and then sit at full
    push_enable = 1'b1;
    push_burst  = 1'b1;
    while (!push_full) @(negedge push_clk);
    repeat (20) @(negedge push_clk);

    // Full drain with sparse pushes
    push_burst = 1'b0;
    pop_mode   = mode_drain;
    repeat (40) @(negedge pop_clk);

    // Random traffic on both sides until every word is in
    pop_mode = mode_random;
    while (push_total < num_words) @(negedge pop_clk);

    // Reference queue runs dry, then the FIFO must report empty
    pop_mode = mode_drain;
    while (pop_total < push_total) @(negedge pop_clk);

    if (pop_empty) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      report_mismatch("drain_empty", 1, int'(pop_empty));
    end
  end

  // Bound on the whole run
  initial begin : watchdog
    #(watchdog_ns);
    $display("ERROR: watchdog expired before the FIFO drained, %0d of %0d words out",
             pop_total, num_words);
    stop_on_failure();
  end

endmodule

// File: cdc_fifo.f
common/cdc_fifo_pkg.sv
rtl/gray_count_sync.sv
rtl/dual_clock_ram.sv
cdc_fifo/cdc_fifo_ctrl_push.sv
cdc_fifo/cdc_fifo_pop_ctrl.sv
cdc_fifo/cdc_fifo_ctrl_pop.sv
cdc_fifo/cdc_fifo.sv
dv/cdc_fifo_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= cdc_fifo_tb
FILELIST  ?= cdc_fifo.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
